// File: dp_assert.sv
/*
 * Concurrent checks bound into dp_top. Reads the internal control word,
 * so the bind relies on the ctrl net name inside dp_top.
 */
module dp_assert
(
    input logic                cpu_clock,
    input logic                reset,
    input dp_pkg::ctrl_word_t  ctrl,
    input dp_pkg::dp_status_t  status,
    input dp_pkg::dp_word_t    a0
);

    import dp_pkg::*;

    int   failures = 0;   // Count of failed properties
    logic quiet_op;       // Neither arithmetic nor a shift left or right
    logic a0_hold;

    assign quiet_op = (ctrl.alu_op inside {alu_pass, alu_xor, alu_and, alu_or}) &&
                      !(ctrl.shift_op inside {shift_sl, shift_sr});
    assign a0_hold  = !(ctrl.a0_wr inside {a_wr_alu, a_wr_d});

    ////////////////////////////////////////////////////////////////////////////
    // Properties
    ////////////////////////////////////////////////////////////////////////////

    status_zero_in_reset: assert property (
        @(posedge cpu_clock) reset |-> (status == '0)
    ) else
    begin
        failures++;
        $error("status not zero during reset");
    end

    // Carry, overflow and shift-out stay clear after a quiet op
    quiet_flags_clear: assert property (
        @(posedge cpu_clock) disable iff (reset)
        quiet_op |=> (!status.co && !status.ov && !status.so)
    ) else
    begin
        failures++;
        $error("co, ov or so set after a logic op");
    end

    a0_holds: assert property (
        @(posedge cpu_clock) disable iff (reset)
        a0_hold |=> $stable(a0)
    ) else
    begin
        failures++;
        $error("a0 changed without a write");
    end

endmodule

bind dp_top dp_assert u_dp_assert
(
    .cpu_clock (cpu_clock),
    .reset     (reset),
    .ctrl      (ctrl),
    .status    (status),
    .a0        (a0)
);

// File: dp_ctrl_store.sv
/*
 * Control store of DP_CS_DEPTH words. Writes land on the clock edge,
 * the selected word is read combinationally from cs_addr.
 */
`include "dp_macros.svh"

module dp_ctrl_store
(
    input  logic                   cpu_clock,
    input  logic                   reset,
    input  logic                   cs_write,
    input  logic [`DP_CS_AW-1:0]   cs_wr_addr,
    input  dp_pkg::ctrl_word_t     cs_wr_data,
    input  logic [`DP_CS_AW-1:0]   cs_addr,
    output dp_pkg::ctrl_word_t     ctrl,
    output logic                   arith_ci
);

    import dp_pkg::*;

    ctrl_word_t cs_mem [`DP_CS_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    // Cleared words decode as pass with no writes
    always_ff @(posedge cpu_clock or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < `DP_CS_DEPTH; i++)
            begin
                cs_mem[i] <= '0;
            end
        end
        else if (cs_write)
        begin
            cs_mem[cs_wr_addr] <= cs_wr_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read and carry decode
    ////////////////////////////////////////////////////////////////////////////

    assign ctrl = cs_mem[cs_addr];   // Active word for this cycle

    // Inc adds zero plus one, sub adds the complement plus one
    always_comb
    begin
        case (ctrl.alu_op)
            alu_inc: arith_ci = 1'b1;
            alu_sub: arith_ci = 1'b1;
            default: arith_ci = 1'b0;
        endcase
    end

endmodule

// File: dp_macros.svh
/*
 * Datapath sizing. The opcode tables and the nibble swap assume byte
 * slices, so DP_WIDTH stays at 8. DP_SLICES may be set to any count >= 1.
 */
`ifndef DP_MACROS_SVH
`define DP_MACROS_SVH

`define DP_WIDTH     8     // Bits per slice
`define DP_SLICES    2     // Chained slices, LSB slice is index 0

// Control store
`define DP_CS_DEPTH  8     // Control words
`define DP_CS_AW     3     // Address width for DP_CS_DEPTH words

`endif

// File: dp_pkg.sv
/*
 * Shared types of the chained datapath. Enum encodings are the control
 * store bit patterns, so a zero word means pass, no shift, no writes.
 */
`include "dp_macros.svh"

package dp_pkg;

    // ALU operation, carry-in for slice 0 is decoded from this
    typedef enum logic [2:0] {
        alu_pass = 3'd0,
        alu_inc  = 3'd1,
        alu_dec  = 3'd2,
        alu_add  = 3'd3,
        alu_sub  = 3'd4,
        alu_xor  = 3'd5,
        alu_and  = 3'd6,
        alu_or   = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        shift_pass = 2'd0,
        shift_sl   = 2'd1,
        shift_sr   = 2'd2,
        shift_swap = 2'd3    // Nibble swap within each byte
    } shift_op_t;

    typedef enum logic [1:0] {
        src_b_d0 = 2'd0,
        src_b_d1 = 2'd1,
        src_b_a0 = 2'd2,
        src_b_a1 = 2'd3
    } src_b_t;

    // Accumulator write source; A0 loads D0, A1 loads D1
    typedef enum logic [1:0] {
        a_wr_none = 2'd0,
        a_wr_alu  = 2'd1,
        a_wr_d    = 2'd2
    } a_wr_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src_a;      // 0 selects A0, 1 selects A1
        src_b_t    src_b;
        shift_op_t shift_op;
        a_wr_t     a0_wr;
        a_wr_t     a1_wr;
    } ctrl_word_t;

    typedef struct packed {
        logic ce;              // Equal
        logic cl;              // Less than
        logic z;               // Zero
        logic ff;              // All ones
    } cmp_flags_t;

    typedef struct packed {
        cmp_flags_t cmp0;      // A0 against D0
        cmp_flags_t cmp1;      // A1 against D1
        logic       co;
        logic       ov;
        logic       so;
    } dp_status_t;

    typedef logic [`DP_WIDTH-1:0]            byte_t;
    typedef logic [`DP_WIDTH*`DP_SLICES-1:0] dp_word_t;

endpackage

// File: dp_slice.sv
/*
 * One byte slice: accumulators, data registers, ALU, shifter and two
 * chained comparators. Chain outputs are combinational from the current
 * registers and control word, so a long chain sets the cycle time.
 */
`include "dp_macros.svh"

module dp_slice
#(
    parameter int SLICE_INDEX = 0      // Byte position within the word
)
(
    input  logic                cpu_clock,
    input  logic                reset,
    input  dp_pkg::ctrl_word_t  ctrl,
    input  logic                d_write,
    input  logic                d_sel,     // 0 loads D0, 1 loads D1
    input  dp_pkg::dp_word_t    d_data,
    input  logic                ci,
    input  logic                sil,
    input  logic                sir,
    input  dp_pkg::cmp_flags_t  cmp0_in,
    input  dp_pkg::cmp_flags_t  cmp1_in,
    output logic                co,
    output logic                sol,
    output logic                sor,
    output dp_pkg::cmp_flags_t  cmp0_out,
    output dp_pkg::cmp_flags_t  cmp1_out,
    output dp_pkg::byte_t       a0,
    output dp_pkg::byte_t       a1,
    output logic                src_a_msb,
    output logic                src_b_msb,
    output logic                sum_msb
);

    import dp_pkg::*;

    byte_t             d0;
    byte_t             d1;
    byte_t             d_byte;
    byte_t             src_a;
    byte_t             src_b;
    byte_t             add_b;       // Adder operand after inc/dec/sub
    logic [`DP_WIDTH:0] sum;
    byte_t             alu_out;
    byte_t             shift_out;

    // One comparator stage, chained from the lower byte
    function automatic cmp_flags_t compare(input byte_t a, input byte_t d,
                                           input cmp_flags_t chain_in);
        cmp_flags_t f;
        f.ce = (a == d) && chain_in.ce;
        f.cl = (a < d) || (chain_in.cl && (a == d));  // Upper byte decides
        f.z  = (a == '0) && chain_in.z;
        f.ff = (a == '1) && chain_in.ff;
        return f;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////////////////////////////////////////

    assign d_byte = d_data[SLICE_INDEX*`DP_WIDTH +: `DP_WIDTH];
    assign src_a  = ctrl.src_a ? a1 : a0;

    always_comb
    begin
        case (ctrl.src_b)
            src_b_d0: src_b = d0;
            src_b_d1: src_b = d1;
            src_b_a0: src_b = a0;
            default:  src_b = a1;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (ctrl.alu_op)
            alu_inc: add_b = '0;          // Carry supplies the one
            alu_dec: add_b = '1;
            alu_sub: add_b = ~src_b;
            default: add_b = src_b;
        endcase
    end

    assign sum = {1'b0, src_a} + {1'b0, add_b} + {{`DP_WIDTH{1'b0}}, ci};

    always_comb
    begin
        case (ctrl.alu_op)
            alu_pass: alu_out = src_a;
            alu_xor:  alu_out = src_a ^ src_b;
            alu_and:  alu_out = src_a & src_b;
            alu_or:   alu_out = src_a | src_b;
            default:  alu_out = sum[`DP_WIDTH-1:0];   // inc, dec, add, sub
        endcase
    end

    // Carry runs on for every op; status masks it off for logic ops
    assign co        = sum[`DP_WIDTH];
    assign src_a_msb = src_a[`DP_WIDTH-1];
    assign src_b_msb = add_b[`DP_WIDTH-1];
    assign sum_msb   = sum[`DP_WIDTH-1];

    ////////////////////////////////////////////////////////////////////////////
    // Shifter
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (ctrl.shift_op)
            shift_sl:   shift_out = {alu_out[`DP_WIDTH-2:0], sil};
            shift_sr:   shift_out = {sir, alu_out[`DP_WIDTH-1:1]};
            shift_swap: shift_out = {alu_out[3:0], alu_out[7:4]};
            default:    shift_out = alu_out;
        endcase
    end

    assign sol = alu_out[`DP_WIDTH-1];  // Into next slice on shift left
    assign sor = alu_out[0];            // Into lower slice on shift right

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge cpu_clock or posedge reset)
    begin
        if (reset)
        begin
            a0 <= '0;
            a1 <= '0;
            d0 <= '0;
            d1 <= '0;
        end
        else
        begin
            case (ctrl.a0_wr)
                a_wr_alu: a0 <= shift_out;
                a_wr_d:   a0 <= d0;
                default:  a0 <= a0;
            endcase
            case (ctrl.a1_wr)
                a_wr_alu: a1 <= shift_out;
                a_wr_d:   a1 <= d1;
                default:  a1 <= a1;
            endcase
            if (d_write && !d_sel)
            begin
                d0 <= d_byte;
            end
            if (d_write && d_sel)
            begin
                d1 <= d_byte;
            end
        end
    end

    // Compare chains
    assign cmp0_out = compare(a0, d0, cmp0_in);
    assign cmp1_out = compare(a1, d1, cmp1_in);

endmodule

// File: dp_status_reg.sv
/*
 * Status register stage. Carry and overflow are reported for arithmetic
 * ops only, shift-out for shift left and right only; all bits registered.
 */
module dp_status_reg
(
    input  logic                cpu_clock,
    input  logic                reset,
    input  dp_pkg::ctrl_word_t  ctrl,
    input  dp_pkg::cmp_flags_t  cmp0,
    input  dp_pkg::cmp_flags_t  cmp1,
    input  logic                co_top,
    input  logic                sol_top,
    input  logic                sor_low,
    input  logic                src_a_msb,
    input  logic                src_b_msb,
    input  logic                sum_msb,
    output dp_pkg::dp_status_t  status
);

    import dp_pkg::*;

    logic       arith;
    logic       signed_ov;
    dp_status_t status_next;

    assign arith = ctrl.alu_op inside {alu_inc, alu_dec, alu_add, alu_sub};

    // Same-sign operands giving an opposite-sign sum
    assign signed_ov = (src_a_msb & src_b_msb & ~sum_msb) |
                       (~src_a_msb & ~src_b_msb & sum_msb);

    always_comb
    begin
        status_next.cmp0 = cmp0;
        status_next.cmp1 = cmp1;
        status_next.co   = arith & co_top;
        status_next.ov   = arith & signed_ov;
        case (ctrl.shift_op)
            shift_sl: status_next.so = sol_top;   // MSB of the word
            shift_sr: status_next.so = sor_low;   // LSB of the word
            default:  status_next.so = 1'b0;
        endcase
    end

    always_ff @(posedge cpu_clock or posedge reset)
    begin
        if (reset)
        begin
            status <= '0;
        end
        else
        begin
            status <= status_next;
        end
    end

endmodule

// File: dp_top.sv
/*
 * Chained datapath of DP_SLICES byte slices. Slice 0 holds the low byte.
 * shift_in feeds both ends of the shift chain; the op picks which is used.
 */
`include "dp_macros.svh"

module dp_top
(
    input  logic                    cpu_clock,
    input  logic                    reset,
    input  logic                    cs_write,
    input  logic [`DP_CS_AW-1:0]    cs_wr_addr,
    input  dp_pkg::ctrl_word_t      cs_wr_data,
    input  logic [`DP_CS_AW-1:0]    cs_addr,
    input  logic                    d_write,
    input  logic                    d_sel,
    input  dp_pkg::dp_word_t        d_data,
    input  logic                    shift_in,
    output wire dp_pkg::dp_word_t   a0,
    output wire dp_pkg::dp_word_t   a1,
    output dp_pkg::dp_status_t      status
);

    import dp_pkg::*;

    // Neutral compare seed for the low byte; less must start clear
    localparam cmp_flags_t cmp_seed = '{ce: 1'b1, cl: 1'b0, z: 1'b1, ff: 1'b1};

    ctrl_word_t            ctrl;
    wire                   arith_ci;
    wire [`DP_SLICES:0]    carry_chain;     // [i] into slice i
    wire [`DP_SLICES:0]    sl_chain;        // [i] into slice i sil
    wire [`DP_SLICES:0]    sr_chain;        // [i+1] into slice i sir
    wire cmp_flags_t       cmp0_chain [`DP_SLICES+1];
    wire cmp_flags_t       cmp1_chain [`DP_SLICES+1];
    wire [`DP_SLICES-1:0]  src_a_msb;
    wire [`DP_SLICES-1:0]  src_b_msb;
    wire [`DP_SLICES-1:0]  sum_msb;

    dp_ctrl_store u_ctrl_store
    (
        .cpu_clock  (cpu_clock),
        .reset      (reset),
        .cs_write   (cs_write),
        .cs_wr_addr (cs_wr_addr),
        .cs_wr_data (cs_wr_data),
        .cs_addr    (cs_addr),
        .ctrl       (ctrl),
        .arith_ci   (arith_ci)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Chain ends
    ////////////////////////////////////////////////////////////////////////////

    assign carry_chain[0]          = arith_ci;
    assign sl_chain[0]             = shift_in;
    assign sr_chain[`DP_SLICES]    = shift_in;
    assign cmp0_chain[0]           = cmp_seed;
    assign cmp1_chain[0]           = cmp_seed;

    for (genvar i = 0; i < `DP_SLICES; i++)
    begin : g_slice
        dp_slice #(.SLICE_INDEX(i)) u_slice
        (
            .cpu_clock (cpu_clock),
            .reset     (reset),
            .ctrl      (ctrl),
            .d_write   (d_write),
            .d_sel     (d_sel),
            .d_data    (d_data),
            .ci        (carry_chain[i]),
            .sil       (sl_chain[i]),
            .sir       (sr_chain[i+1]),
            .cmp0_in   (cmp0_chain[i]),
            .cmp1_in   (cmp1_chain[i]),
            .co        (carry_chain[i+1]),
            .sol       (sl_chain[i+1]),
            .sor       (sr_chain[i]),
            .cmp0_out  (cmp0_chain[i+1]),
            .cmp1_out  (cmp1_chain[i+1]),
            .a0        (a0[i*`DP_WIDTH +: `DP_WIDTH]),
            .a1        (a1[i*`DP_WIDTH +: `DP_WIDTH]),
            .src_a_msb (src_a_msb[i]),
            .src_b_msb (src_b_msb[i]),
            .sum_msb   (sum_msb[i])
        );
    end

    // Only the top slice MSBs matter for overflow
    dp_status_reg u_status_reg
    (
        .cpu_clock (cpu_clock),
        .reset     (reset),
        .ctrl      (ctrl),
        .cmp0      (cmp0_chain[`DP_SLICES]),
        .cmp1      (cmp1_chain[`DP_SLICES]),
        .co_top    (carry_chain[`DP_SLICES]),
        .sol_top   (sl_chain[`DP_SLICES]),
        .sor_low   (sr_chain[0]),
        .src_a_msb (src_a_msb[`DP_SLICES-1]),
        .src_b_msb (src_b_msb[`DP_SLICES-1]),
        .sum_msb   (sum_msb[`DP_SLICES-1]),
        .status    (status)
    );

endmodule

// File: list.f
+incdir+.
dp_pkg.sv
dp_ctrl_store.sv
dp_slice.sv
dp_status_reg.sv
dp_top.sv
dp_assert.sv
tb_dp_top.sv

// File: tb_dp_top.sv
/*
 * Directed testbench for the chained datapath. A word-level model of the
 * ALU, shifter and compare rules predicts a0, a1 and status on every step.
 * Random operands fill at most 64 bits of the word.
 */
`include "dp_macros.svh"

module tb_dp_top;

    import dp_pkg::*;

    localparam int W           = `DP_WIDTH * `DP_SLICES;
    // Reset, arithmetic, logic, compare and sequencing cycles
    localparam int TEST_CYCLES = 3 + 55 + 32 + 25 + 20;
    localparam int TIMEOUT     = TEST_CYCLES * 100 + 2000;

    logic                 cpu_clock;
    logic                 reset;
    logic                 cs_write;
    logic [`DP_CS_AW-1:0] cs_wr_addr;
    ctrl_word_t           cs_wr_data;
    logic [`DP_CS_AW-1:0] cs_addr;
    logic                 d_write;
    logic                 d_sel;
    dp_word_t             d_data;
    logic                 shift_in;
    dp_word_t             a0;
    dp_word_t             a1;
    dp_status_t           status;

    // Model state
    ctrl_word_t cs_m [`DP_CS_DEPTH];
    dp_word_t   acc0_m;
    dp_word_t   acc1_m;
    dp_word_t   d0_m;
    dp_word_t   d1_m;
    int         errors;
    int         checks;
    int         assert_fails;

    dp_top u_dp_top
    (
        .cpu_clock  (cpu_clock),
        .reset      (reset),
        .cs_write   (cs_write),
        .cs_wr_addr (cs_wr_addr),
        .cs_wr_data (cs_wr_data),
        .cs_addr    (cs_addr),
        .d_write    (d_write),
        .d_sel      (d_sel),
        .d_data     (d_data),
        .shift_in   (shift_in),
        .a0         (a0),
        .a1         (a1),
        .status     (status)
    );

    always #50 cpu_clock = ~cpu_clock;

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_word(input string what, input dp_word_t got, input dp_word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input dp_status_t got, input dp_status_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0t: status got %b %b %b %b %b, expected %b %b %b %b %b",
                     $time, got.cmp0, got.cmp1, got.co, got.ov, got.so,
                     exp.cmp0, exp.cmp1, exp.co, exp.ov, exp.so);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic cmp_flags_t cmp_model(input dp_word_t a, input dp_word_t d);
        cmp_flags_t f;
        f.ce = (a == d);
        f.cl = (a < d);
        f.z  = (a == '0);
        f.ff = (a == '1);
        return f;
    endfunction

    function automatic ctrl_word_t make_word(input alu_op_t op, input logic sa, input src_b_t sb,
                                             input shift_op_t sh, input a_wr_t w0, input a_wr_t w1);
        ctrl_word_t w;
        w.alu_op   = op;
        w.src_a    = sa;
        w.src_b    = sb;
        w.shift_op = sh;
        w.a0_wr    = w0;
        w.a1_wr    = w1;
        return w;
    endfunction

    task automatic predict(input ctrl_word_t w, input logic sin, output dp_word_t n0,
                           output dp_word_t n1, output dp_status_t st);
        dp_word_t   a;
        dp_word_t   b;
        dp_word_t   b_eff;          // Adder operand after conversion
        dp_word_t   r;
        dp_word_t   sh;
        logic [W:0] wide;
        logic       arith;
        a     = w.src_a ? acc1_m : acc0_m;
        case (w.src_b)
            src_b_d0: b = d0_m;
            src_b_d1: b = d1_m;
            src_b_a0: b = acc0_m;
            default:  b = acc1_m;
        endcase
        arith = 1'b1;
        b_eff = b;
        st    = '0;
        case (w.alu_op)
            alu_inc:
            begin
                r     = a + 1'b1;
                b_eff = '0;
                st.co = (a == '1);
            end
            alu_dec:
            begin
                r     = a - 1'b1;
                b_eff = '1;
                st.co = (a != '0);
            end
            alu_add:
            begin
                wide  = {1'b0, a} + {1'b0, b};
                r     = wide[W-1:0];
                st.co = wide[W];
            end
            alu_sub:
            begin
                r     = a - b;
                b_eff = ~b;
                st.co = (a >= b);   // No borrow
            end
            alu_xor: r = a ^ b;
            alu_and: r = a & b;
            alu_or:  r = a | b;
            default: r = a;
        endcase
        if (alu_op_t'(w.alu_op) inside {alu_pass, alu_xor, alu_and, alu_or})
        begin
            arith = 1'b0;
        end
        // Same-sign adder inputs, opposite-sign result
        st.ov = arith && (a[W-1] == b_eff[W-1]) && (r[W-1] != a[W-1]);
        sh = r;
        case (w.shift_op)
            shift_sl:
            begin
                sh    = {r[W-2:0], sin};
                st.so = r[W-1];
            end
            shift_sr:
            begin
                sh    = {sin, r[W-1:1]};
                st.so = r[0];
            end
            shift_swap:
            begin
                for (int k = 0; k < `DP_SLICES; k++)
                begin
                    sh[k*8 +: 8] = {r[k*8 +: 4], r[k*8+4 +: 4]};
                end
            end
            default: sh = r;
        endcase
        n0 = (w.a0_wr == a_wr_alu) ? sh : (w.a0_wr == a_wr_d) ? d0_m : acc0_m;
        n1 = (w.a1_wr == a_wr_alu) ? sh : (w.a1_wr == a_wr_d) ? d1_m : acc1_m;
        st.cmp0 = cmp_model(acc0_m, d0_m);
        st.cmp1 = cmp_model(acc1_m, d1_m);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drivers, all entered 10 units after a rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic write_cs(input int addr, input ctrl_word_t w);
        cs_write   = 1'b1;
        cs_wr_addr = addr;
        cs_wr_data = w;
        @(posedge cpu_clock);
        #10;
        cs_write   = 1'b0;
        cs_m[addr] = w;
    endtask

    task automatic load_d(input logic sel, input dp_word_t value);
        d_write = 1'b1;
        d_sel   = sel;
        d_data  = value;
        @(posedge cpu_clock);
        #10;
        d_write = 1'b0;
        if (sel)
            d1_m = value;
        else
            d0_m = value;
    endtask

    // Run one cycle on word addr and check everything after the edge
    task automatic step(input int addr, input logic sin);
        dp_word_t   n0;
        dp_word_t   n1;
        dp_status_t st;
        predict(cs_m[addr], sin, n0, n1, st);
        cs_addr  = addr;
        shift_in = sin;
        @(posedge cpu_clock);
        #10;
        acc0_m = n0;
        acc1_m = n1;
        check_word("a0", a0, n0);
        check_word("a1", a1, n1);
        check_status(status, st);
        cs_addr  = '0;
        shift_in = 1'b0;
    endtask

    task automatic report(input string name, input int err_before);
        $display("Test %s finished with %0d errors", name, errors - err_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        int e;
        e = errors;
        check_word("a0", a0, '0);
        check_word("a1", a1, '0);
        check_status(status, '0);
        report("reset", e);
    endtask

    task automatic test_arith();
        int       e;
        dp_word_t x;
        dp_word_t y;
        e = errors;
        write_cs(1, make_word(alu_pass, 0, src_b_d0, shift_pass, a_wr_d, a_wr_d));
        write_cs(2, make_word(alu_add, 0, src_b_d1, shift_pass, a_wr_alu, a_wr_none));
        write_cs(3, make_word(alu_sub, 0, src_b_d1, shift_pass, a_wr_alu, a_wr_none));
        write_cs(4, make_word(alu_inc, 0, src_b_d1, shift_pass, a_wr_alu, a_wr_none));
        write_cs(5, make_word(alu_dec, 0, src_b_d1, shift_pass, a_wr_alu, a_wr_none));
        for (int n = 0; n < 5; n++)
        begin
            x = {$urandom, $urandom};
            y = {$urandom, $urandom};
            if (n == 0)
            begin
                x = {1'b0, {(W-1){1'b1}}};   // Largest positive value
                y = 1;
            end
            if (n == 1)
            begin
                x = '1;                      // Carry out of every op
                y = '1;
            end
            load_d(0, x);
            load_d(1, y);
            for (int k = 2; k <= 5; k++)
            begin
                step(1, 0);
                step(k, 0);
            end
        end
        report("arithmetic", e);
    endtask

    task automatic test_logic();
        int e;
        e = errors;
        write_cs(2, make_word(alu_xor, 0, src_b_d1, shift_pass, a_wr_alu, a_wr_none));
        write_cs(3, make_word(alu_and, 0, src_b_d1, shift_pass, a_wr_alu, a_wr_none));
        write_cs(4, make_word(alu_or, 1, src_b_d0, shift_pass, a_wr_alu, a_wr_none));
        write_cs(5, make_word(alu_pass, 1, src_b_d0, shift_sl, a_wr_alu, a_wr_none));
        write_cs(6, make_word(alu_pass, 0, src_b_d0, shift_sr, a_wr_alu, a_wr_none));
        write_cs(7, make_word(alu_pass, 0, src_b_d0, shift_swap, a_wr_alu, a_wr_alu));
        load_d(0, {$urandom, $urandom});
        load_d(1, {$urandom, $urandom});
        for (int k = 2; k <= 7; k++)
        begin
            for (int s = 0; s < 2; s++)
            begin
                step(1, 0);
                step(k, s[0]);
            end
        end
        report("logic and shift", e);
    endtask

    task automatic compare_case(input dp_word_t a0v, input dp_word_t d0v,
                                input dp_word_t a1v, input dp_word_t d1v);
        load_d(0, a0v);
        load_d(1, a1v);
        step(1, 0);
        load_d(0, d0v);
        load_d(1, d1v);
        step(0, 0);
    endtask

    task automatic test_compare();
        int       e;
        dp_word_t r;
        dp_word_t s;
        e = errors;
        write_cs(1, make_word(alu_pass, 0, src_b_d0, shift_pass, a_wr_d, a_wr_d));
        r = {$urandom, $urandom};
        s = {$urandom, $urandom};
        compare_case(r, r, s, s);
        compare_case(r, r ^ 1, s, s ^ 8'h80);    // Low byte differs only
        compare_case('0, '0, '1, '1);
        compare_case('1, '0, '0, '1);
        report("compare", e);
    endtask

    // Words alternate between accumulator writes and no writes
    task automatic test_sequence();
        int e;
        e = errors;
        write_cs(1, make_word(alu_pass, 0, src_b_d0, shift_pass, a_wr_d, a_wr_none));
        write_cs(2, make_word(alu_xor, 0, src_b_d1, shift_pass, a_wr_none, a_wr_none));
        write_cs(3, make_word(alu_inc, 0, src_b_d0, shift_pass, a_wr_alu, a_wr_none));
        write_cs(4, make_word(alu_and, 0, src_b_d1, shift_sl, a_wr_none, a_wr_none));
        write_cs(5, make_word(alu_add, 0, src_b_d1, shift_sl, a_wr_alu, a_wr_none));
        write_cs(6, make_word(alu_pass, 0, src_b_d0, shift_sr, a_wr_none, a_wr_none));
        load_d(0, {$urandom, $urandom});
        load_d(1, {$urandom, $urandom});
        for (int pass = 0; pass < 2; pass++)
        begin
            for (int k = 1; k <= 6; k++)
            begin
                step(k, $urandom % 2);
            end
        end
        report("sequencing", e);
    endtask

    // Watchdog
    initial
    begin
        #(TIMEOUT);
        $display("Timeout: the tests did not finish in %0d time units", TIMEOUT);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        void'($urandom(32'hafa6_1c29));
        errors       = 0;
        checks       = 0;
        assert_fails = 0;
        cpu_clock    = 1'b0;
        reset        = 1'b1;
        cs_write     = 1'b0;
        cs_wr_addr   = '0;
        cs_wr_data   = '0;
        cs_addr      = '0;
        d_write      = 1'b0;
        d_sel        = 1'b0;
        d_data       = '0;
        shift_in     = 1'b0;
        acc0_m       = '0;
        acc1_m       = '0;
        d0_m         = '0;
        d1_m         = '0;
        for (int i = 0; i < `DP_CS_DEPTH; i++)
        begin
            cs_m[i] = '0;
        end
        repeat (3) @(posedge cpu_clock);
        #10;
        reset = 1'b0;
        test_reset();
        test_arith();
        test_logic();
        test_compare();
        test_sequence();
        assert_fails = u_dp_top.u_dp_assert.failures;
        $display("Done: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
